/* verilog/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data path width
`define XLEN 32

// architectural registers, r0 reads as zero
`define REG_COUNT 32

// instruction memory is word addressed
`define IM_AW 10

// data memory is byte addressed
`define DM_AW 12

`endif

/* verilog/core_pkg.sv */
package core_pkg;

	// major opcodes, all-zero word is add r0, r0, r0
	typedef enum logic [5:0] {
		OP_ALU  = 6'h00,
		OP_ADDI = 6'h01,
		OP_ORI  = 6'h02,
		OP_LW   = 6'h03,
		OP_SW   = 6'h04
	} op_e;

	// values follow the funct encoding of OP_ALU
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLT = 4'd5,
		ALU_SLL = 4'd6,
		ALU_SRL = 4'd7
	} alu_op_e;

	typedef union packed {
		struct packed {
			op_e opcode;
			logic [4:0] rt;
			logic [4:0] ra;
			logic [4:0] rb;
			logic [5:0] unused;
			logic [4:0] funct;
		} r;
		struct packed {
			op_e opcode;
			logic [4:0] rt;
			logic [4:0] ra;
			logic [15:0] imm16;
		} i;
	} instr_t;

	typedef struct packed {
		alu_op_e alu_op;
		logic use_imm;
		logic reg_write;
		logic dm_read;
		logic dm_write;
	} ctrl_t;

endpackage

/* verilog/bypass_if.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

interface bypass_if;
	logic [4:0] ex_dest;
	logic ex_reg_write;
	logic ex_is_load;
	logic [`XLEN-1:0] ex_result;

	logic [4:0] mem_dest;
	logic mem_reg_write;
	logic [`XLEN-1:0] mem_value;

	logic [4:0] wb_dest;
	logic wb_reg_write;
	logic [`XLEN-1:0] wb_value;

	modport stages (output ex_dest, ex_reg_write, ex_is_load, ex_result,
		mem_dest, mem_reg_write, mem_value, wb_dest, wb_reg_write, wb_value);

	modport unit (input ex_dest, ex_reg_write, ex_is_load, ex_result,
		mem_dest, mem_reg_write, mem_value, wb_dest, wb_reg_write, wb_value);
endinterface

/* verilog/decoder.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module decoder (
	input core_pkg::instr_t instr,
	input logic valid,
	output logic [4:0] ra_addr,
	output logic [4:0] rb_addr,
	output logic [4:0] rt_addr,
	output logic [`XLEN-1:0] imm,
	output core_pkg::ctrl_t ctrl
);
	import core_pkg::*;

	alu_op_e funct_op;

	always_comb begin
		case (instr.r.funct)
			5'd1: funct_op = ALU_SUB;
			5'd2: funct_op = ALU_AND;
			5'd3: funct_op = ALU_OR;
			5'd4: funct_op = ALU_XOR;
			5'd5: funct_op = ALU_SLT;
			5'd6: funct_op = ALU_SLL;
			5'd7: funct_op = ALU_SRL;
			default: funct_op = ALU_ADD;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = ALU_ADD;
		ra_addr = instr.i.ra;
		rt_addr = instr.i.rt;
		rb_addr = 5'd0;
		imm = {{(`XLEN-16){instr.i.imm16[15]}}, instr.i.imm16};
		case (instr.i.opcode)
			OP_ALU: begin
				rb_addr = instr.r.rb;
				ctrl.alu_op = funct_op;
				ctrl.reg_write = valid;
			end
			OP_ADDI: begin
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = valid;
			end
			OP_ORI: begin
				// logic immediate is zero extended
				imm = {{(`XLEN-16){1'b0}}, instr.i.imm16};
				ctrl.alu_op = ALU_OR;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = valid;
			end
			OP_LW: begin
				ctrl.use_imm = 1'b1;
				ctrl.dm_read = valid;
				ctrl.reg_write = valid;
			end
			OP_SW: begin
				// store data comes through the rb port
				rb_addr = instr.i.rt;
				ctrl.use_imm = 1'b1;
				ctrl.dm_write = valid;
			end
			default: begin
				ctrl.reg_write = 1'b0;
			end
		endcase
	end

	always_comb begin
		if (valid)
			assert final (instr.i.opcode inside {OP_ALU, OP_ADDI, OP_ORI, OP_LW, OP_SW})
				else $error("decoder: unknown opcode %h", instr.i.opcode);
	end
endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module regfile (
	input logic clk,
	input logic arst_n,
	input logic [4:0] ra_addr,
	input logic [4:0] rb_addr,
	input logic wr_en,
	input logic [4:0] wr_addr,
	input logic [`XLEN-1:0] wr_data,
	output logic [`XLEN-1:0] ra_data,
	output logic [`XLEN-1:0] rb_data
);
	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// read ports see the old value during a write
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

	// r0 must hold zero even after a write aimed at it
	a_r0_ra: assert property (
		@(posedge clk) disable iff (!arst_n)
		ra_addr == 5'd0 |-> ra_data == '0
	) else $error("regfile: r0 nonzero on port a");

	a_r0_rb: assert property (
		@(posedge clk) disable iff (!arst_n)
		rb_addr == 5'd0 |-> rb_data == '0
	) else $error("regfile: r0 nonzero on port b");
endmodule

/* verilog/forward.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module forward (
	input logic [4:0] ra_addr,
	input logic [4:0] rb_addr,
	input logic [`XLEN-1:0] ra_data,
	input logic [`XLEN-1:0] rb_data,
	bypass_if.unit byp,
	output logic [`XLEN-1:0] op_a,
	output logic [`XLEN-1:0] op_b,
	output logic stall
);
	logic ra_hit_ex;
	logic rb_hit_ex;

	// youngest producer wins
	function automatic logic [`XLEN-1:0] pick(
		input logic [4:0] addr,
		input logic [`XLEN-1:0] rf_data
	);
		if (addr == 5'd0)
			return rf_data;
		if (byp.ex_reg_write && byp.ex_dest == addr)
			return byp.ex_result;
		if (byp.mem_reg_write && byp.mem_dest == addr)
			return byp.mem_value;
		if (byp.wb_reg_write && byp.wb_dest == addr)
			return byp.wb_value;
		return rf_data;
	endfunction

	assign op_a = pick(ra_addr, ra_data);
	assign op_b = pick(rb_addr, rb_data);

	assign ra_hit_ex = ra_addr != 5'd0 && byp.ex_dest == ra_addr;
	assign rb_hit_ex = rb_addr != 5'd0 && byp.ex_dest == rb_addr;

	// load data only exists in the memory stage
	assign stall = byp.ex_is_load && byp.ex_reg_write && (ra_hit_ex || rb_hit_ex);

	// a load in execute always has a destination to wait for
	always_comb begin
		assert final (!byp.ex_is_load || byp.ex_reg_write)
			else $error("forward: load in execute without a register write");
	end
endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module alu (
	input core_pkg::alu_op_e op,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] result,
	output logic overflow
);
	import core_pkg::*;

	logic [`XLEN-1:0] sum;
	logic [`XLEN-1:0] diff;
	logic [4:0] shamt;

	assign sum = a + b;
	assign diff = a - b;
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			ALU_ADD: result = sum;
			ALU_SUB: result = diff;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_SLL: result = a << shamt;
			ALU_SRL: result = a >> shamt;
			default: result = sum;
		endcase
	end

	// signed overflow: operand signs vs result sign
	always_comb begin
		case (op)
			ALU_ADD:
				overflow = (a[`XLEN-1] == b[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);
			ALU_SUB:
				overflow = (a[`XLEN-1] != b[`XLEN-1]) && (diff[`XLEN-1] != a[`XLEN-1]);
			default:
				overflow = 1'b0;
		endcase
	end
endmodule

/* verilog/core_top.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module core_top (
	input logic clk,
	input logic arst_n,
	input logic [`XLEN-1:0] instr,
	input logic [`XLEN-1:0] dm_rdata,
	output logic [`IM_AW-1:0] im_addr,
	output logic dm_read,
	output logic dm_write,
	output logic [`DM_AW-1:0] dm_addr,
	output logic [`XLEN-1:0] dm_wdata,
	output logic alu_overflow
);
	import core_pkg::*;

	logic [`IM_AW-1:0] pc;
	logic stall;

	// decode stage
	logic id_valid;
	instr_t id_instr;
	logic [4:0] id_ra;
	logic [4:0] id_rb;
	logic [4:0] id_rt;
	logic [`XLEN-1:0] id_imm;
	ctrl_t id_ctrl;
	logic [`XLEN-1:0] ra_data;
	logic [`XLEN-1:0] rb_data;
	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;

	// execute stage
	logic ex_valid;
	ctrl_t ex_ctrl;
	logic [`XLEN-1:0] ex_op_a;
	logic [`XLEN-1:0] ex_op_b;
	logic [`XLEN-1:0] ex_imm;
	logic [4:0] ex_dest;
	logic [`XLEN-1:0] alu_b;
	logic [`XLEN-1:0] alu_result;
	logic alu_ovf;

	// memory and writeback stages
	logic mem_valid;
	ctrl_t mem_ctrl;
	logic [`XLEN-1:0] mem_result;
	logic [`XLEN-1:0] mem_wdata;
	logic [4:0] mem_dest;
	logic [`XLEN-1:0] mem_value;
	logic wb_valid;
	logic wb_write;
	logic [4:0] wb_dest;
	logic [`XLEN-1:0] wb_value;

	bypass_if byp ();

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
			id_valid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + 1'b1;
			id_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall)
			id_instr <= instr;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
			ex_ctrl <= '0;
			mem_valid <= 1'b0;
			mem_ctrl <= '0;
			wb_valid <= 1'b0;
			wb_write <= 1'b0;
			alu_overflow <= 1'b0;
		end else begin
			// a stall leaves a bubble in execute
			ex_valid <= id_valid && !stall;
			ex_ctrl <= id_ctrl;
			mem_valid <= ex_valid;
			mem_ctrl <= ex_ctrl;
			wb_valid <= mem_valid;
			wb_write <= mem_ctrl.reg_write;
			alu_overflow <= ex_valid && alu_ovf && !ex_ctrl.dm_read && !ex_ctrl.dm_write;
		end
	end

	always_ff @(posedge clk) begin
		ex_op_a <= op_a;
		ex_op_b <= op_b;
		ex_imm <= id_imm;
		ex_dest <= id_rt;
		mem_result <= alu_result;
		mem_wdata <= ex_op_b;
		mem_dest <= ex_dest;
		wb_value <= mem_value;
		wb_dest <= mem_dest;
	end

	assign im_addr = pc;
	assign alu_b = ex_ctrl.use_imm ? ex_imm : ex_op_b;

	assign dm_read = mem_valid && mem_ctrl.dm_read;
	assign dm_write = mem_valid && mem_ctrl.dm_write;
	assign dm_addr = mem_result[`DM_AW-1:0];
	assign dm_wdata = mem_wdata;
	assign mem_value = mem_ctrl.dm_read ? dm_rdata : mem_result;

	assign byp.ex_dest = ex_dest;
	assign byp.ex_reg_write = ex_valid && ex_ctrl.reg_write;
	assign byp.ex_is_load = ex_valid && ex_ctrl.dm_read;
	assign byp.ex_result = alu_result;
	assign byp.mem_dest = mem_dest;
	assign byp.mem_reg_write = mem_valid && mem_ctrl.reg_write;
	assign byp.mem_value = mem_value;
	assign byp.wb_dest = wb_dest;
	assign byp.wb_reg_write = wb_valid && wb_write;
	assign byp.wb_value = wb_value;

	decoder decoder_inst (.instr(id_instr), .valid(id_valid), .ra_addr(id_ra),
		.rb_addr(id_rb), .rt_addr(id_rt), .imm(id_imm), .ctrl(id_ctrl));

	regfile regfile_inst (.clk(clk), .arst_n(arst_n), .ra_addr(id_ra), .rb_addr(id_rb),
		.wr_en(byp.wb_reg_write), .wr_addr(wb_dest), .wr_data(wb_value),
		.ra_data(ra_data), .rb_data(rb_data));

	forward forward_inst (.ra_addr(id_ra), .rb_addr(id_rb), .ra_data(ra_data),
		.rb_data(rb_data), .byp(byp), .op_a(op_a), .op_b(op_b), .stall(stall));

	alu alu_inst (.op(ex_ctrl.alu_op), .a(ex_op_a), .b(alu_b), .result(alu_result),
		.overflow(alu_ovf));

	// the bubble behind a load clears the hazard
	a_stall_single: assert property (
		@(posedge clk) disable iff (!arst_n)
		stall |=> !stall
	) else $error("core_top: stall held for two cycles");

	a_dm_exclusive: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(dm_read && dm_write)
	) else $error("core_top: data memory read and write together");
endmodule

/* verification/core_tb.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module core_tb;
	import core_pkg::*;

	localparam int TIMEOUT = 200;
	// funct field of register-register words
	localparam logic [4:0] FN_ADD = 5'd0;
	localparam logic [4:0] FN_SUB = 5'd1;
	localparam logic [4:0] FN_AND = 5'd2;
	localparam logic [4:0] FN_OR = 5'd3;
	localparam logic [4:0] FN_XOR = 5'd4;
	localparam logic [4:0] FN_SLT = 5'd5;
	localparam logic [4:0] FN_SLL = 5'd6;
	localparam logic [4:0] FN_SRL = 5'd7;

	logic clk;
	logic arst_n;
	logic [`XLEN-1:0] instr;
	logic [`XLEN-1:0] dm_rdata;
	logic [`IM_AW-1:0] im_addr;
	logic dm_read;
	logic dm_write;
	logic [`DM_AW-1:0] dm_addr;
	logic [`XLEN-1:0] dm_wdata;
	logic alu_overflow;

	logic [`XLEN-1:0] rom [1024];
	logic [`XLEN-1:0] ram [1024];
	logic [`XLEN-1:0] prog [$];
	logic [31:0] rng;
	int errors;
	int checks;
	int ovf_count;
	int ovf_cycle;
	int rd_count;
	int rd_cycle;

	core_top core_top_inst (.*);

	assign instr = rom[im_addr];
	assign dm_rdata = ram[dm_addr[`DM_AW-1:2]];

	// store lands at the edge that ends the memory stage
	always @(posedge clk) begin
		if (dm_write)
			ram[dm_addr[`DM_AW-1:2]] <= dm_wdata;
	end

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] reg_instr(input logic [4:0] funct, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb);
		instr_t w;
		w = '0;
		w.r.opcode = OP_ALU;
		w.r.rt = rt;
		w.r.ra = ra;
		w.r.rb = rb;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic logic [31:0] imm_instr(input op_e op, input logic [4:0] rt,
		input logic [4:0] ra, input logic [15:0] imm16);
		instr_t w;
		w.i.opcode = op;
		w.i.rt = rt;
		w.i.ra = ra;
		w.i.imm16 = imm16;
		return w;
	endfunction

	function automatic logic [31:0] sign_extend(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic logic [31:0] expected_alu(input logic [4:0] funct, input logic [31:0] a,
		input logic [31:0] b);
		case (funct)
			FN_SUB: return a - b;
			FN_AND: return a & b;
			FN_OR: return a | b;
			FN_XOR: return a ^ b;
			FN_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			FN_SLL: return a << b[4:0];
			FN_SRL: return a >> b[4:0];
			default: return a + b;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic fill_ram;
		for (int i = 0; i < 1024; i++)
			ram[i] <= 32'hbad0_0000 | 32'(i);
	endtask

	// hold reset while the new program goes in, padded with nops
	task automatic run_program;
		@(negedge clk);
		arst_n = 1'b0;
		for (int i = 0; i < 1024; i++)
			rom[i] = (i < prog.size()) ? prog[i] : 32'h0;
		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		ovf_count = 0;
		ovf_cycle = -1;
		rd_count = 0;
		rd_cycle = -1;
	endtask

	// cycles counts falling edges since reset release, so it equals the cycle index
	task automatic wait_store(input string name, input logic [`DM_AW-1:0] addr, output int cycles,
		output logic [31:0] data);
		bit found;
		found = 1'b0;
		cycles = 0;
		data = '0;
		while (!found && cycles < TIMEOUT) begin
			if (alu_overflow) begin
				ovf_count++;
				ovf_cycle = cycles;
			end
			if (dm_read) begin
				rd_count++;
				rd_cycle = cycles;
			end
			if (dm_write && dm_addr == addr) begin
				found = 1'b1;
				data = dm_wdata;
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
		if (!found) begin
			errors++;
			$display("Timeout in %s: no store to address %h within %0d cycles", name, addr, TIMEOUT);
		end
	endtask

	task automatic dependent_chain;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [31:0] r4;
		logic [31:0] r5;
		int cycles;
		logic [31:0] data;
		r1 = sign_extend(16'd100);
		r2 = r1 + sign_extend(16'hfff9);
		r3 = r2 + r1;
		r4 = r3 - r1;
		r5 = r4 + r2;
		prog.delete();
		prog.push_back(imm_instr(OP_ADDI, 5'd1, 5'd0, 16'd100));
		prog.push_back(imm_instr(OP_ADDI, 5'd2, 5'd1, 16'hfff9));
		prog.push_back(reg_instr(FN_ADD, 5'd3, 5'd2, 5'd1));
		prog.push_back(reg_instr(FN_SUB, 5'd4, 5'd3, 5'd1));
		prog.push_back(reg_instr(FN_ADD, 5'd5, 5'd4, 5'd2));
		prog.push_back(imm_instr(OP_SW, 5'd5, 5'd0, 16'h0010));
		fill_ram();
		run_program();
		wait_store("chain", 12'h010, cycles, data);
		check("chain result", r5, data);
		// store is word 5, no stalls
		check("chain store cycle", 32'd8, 32'(cycles));
		// no loads in this program
		check("chain read cycles", 32'd0, 32'(rd_count));
	endtask

	task automatic logic_and_shifts;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] expv [8];
		int cycles;
		logic [31:0] data;
		a = 32'h0000_f0f0;
		b = sign_extend(16'hfffd);
		expv[0] = a & b;
		expv[1] = a | b;
		expv[2] = a ^ b;
		expv[3] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
		expv[4] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		expv[5] = a << 4;
		expv[6] = b >> 4;
		// ori zero extends, upper half stays clear
		expv[7] = a | 32'h0000_8001;
		prog.delete();
		prog.push_back(imm_instr(OP_ORI, 5'd1, 5'd0, 16'hf0f0));
		prog.push_back(imm_instr(OP_ADDI, 5'd2, 5'd0, 16'hfffd));
		prog.push_back(imm_instr(OP_ADDI, 5'd3, 5'd0, 16'd4));
		prog.push_back(reg_instr(FN_AND, 5'd4, 5'd1, 5'd2));
		prog.push_back(reg_instr(FN_OR, 5'd5, 5'd1, 5'd2));
		prog.push_back(reg_instr(FN_XOR, 5'd6, 5'd1, 5'd2));
		prog.push_back(reg_instr(FN_SLT, 5'd7, 5'd2, 5'd1));
		prog.push_back(reg_instr(FN_SLT, 5'd8, 5'd1, 5'd2));
		prog.push_back(reg_instr(FN_SLL, 5'd9, 5'd1, 5'd3));
		prog.push_back(reg_instr(FN_SRL, 5'd10, 5'd2, 5'd3));
		prog.push_back(imm_instr(OP_ORI, 5'd11, 5'd1, 16'h8001));
		for (int k = 0; k < 8; k++)
			prog.push_back(imm_instr(OP_SW, 5'(k + 4), 5'd0, 16'(256 + 4 * k)));
		fill_ram();
		run_program();
		wait_store("logic", 12'h11c, cycles, data);
		@(negedge clk);
		for (int k = 0; k < 8; k++)
			check($sformatf("logic result %0d", k), expv[k], ram[64 + k]);
	endtask

	task automatic load_use;
		int cycles;
		logic [31:0] data;
		prog.delete();
		prog.push_back(imm_instr(OP_LW, 5'd1, 5'd0, 16'h0020));
		prog.push_back(imm_instr(OP_ADDI, 5'd2, 5'd1, 16'h0055));
		prog.push_back(imm_instr(OP_SW, 5'd2, 5'd0, 16'h0044));
		fill_ram();
		ram[8] <= 32'h1234_5678;
		run_program();
		wait_store("load-use", 12'h044, cycles, data);
		check("load-use result", 32'h1234_5678 + sign_extend(16'h0055), data);
		// store is word 2, one stall in front of it
		check("load-use store cycle", 32'd6, 32'(cycles));
		// load is word 0, one read in its memory stage
		check("load-use read cycles", 32'd1, 32'(rd_count));
		check("load-use read cycle", 32'd3, 32'(rd_cycle));
	endtask

	task automatic overflow_flag;
		int cycles;
		logic [31:0] data;
		prog.delete();
		prog.push_back(imm_instr(OP_ADDI, 5'd1, 5'd0, 16'hffff));
		prog.push_back(imm_instr(OP_ADDI, 5'd2, 5'd0, 16'd1));
		prog.push_back(reg_instr(FN_SRL, 5'd3, 5'd1, 5'd2));
		prog.push_back(reg_instr(FN_ADD, 5'd4, 5'd3, 5'd2));
		prog.push_back(reg_instr(FN_ADD, 5'd5, 5'd2, 5'd2));
		prog.push_back(imm_instr(OP_SW, 5'd4, 5'd0, 16'h0200));
		fill_ram();
		run_program();
		wait_store("overflow", 12'h200, cycles, data);
		check("overflow result", 32'h7fff_ffff + 32'd1, data);
		check("overflow high cycles", 32'd1, 32'(ovf_count));
		// memory stage of word 3
		check("overflow cycle", 32'd6, 32'(ovf_cycle));
	endtask

	task automatic random_ops;
		logic [31:0] a [16];
		logic [31:0] b [16];
		logic [4:0] fn [16];
		int cycles;
		logic [31:0] data;
		prog.delete();
		fill_ram();
		for (int k = 0; k < 16; k++) begin
			rng = xorshift(rng);
			a[k] = rng;
			rng = xorshift(rng);
			b[k] = rng;
			rng = xorshift(rng);
			fn[k] = {2'b00, rng[2:0]};
			ram[2 * k] <= a[k];
			ram[2 * k + 1] <= b[k];
			prog.push_back(imm_instr(OP_LW, 5'd1, 5'd0, 16'(8 * k)));
			prog.push_back(imm_instr(OP_LW, 5'd2, 5'd0, 16'(8 * k + 4)));
			prog.push_back(reg_instr(fn[k], 5'd3, 5'd1, 5'd2));
			prog.push_back(imm_instr(OP_SW, 5'd3, 5'd0, 16'(1024 + 4 * k)));
		end
		run_program();
		wait_store("random", 12'h43c, cycles, data);
		check("random read cycles", 32'd32, 32'(rd_count));
		@(negedge clk);
		for (int k = 0; k < 16; k++)
			check($sformatf("random pair %0d", k), expected_alu(fn[k], a[k], b[k]), ram[256 + k]);
	endtask

	initial begin
		arst_n = 1'b0;
		errors = 0;
		checks = 0;
		ovf_count = 0;
		ovf_cycle = -1;
		rd_count = 0;
		rd_cycle = -1;
		rng = 32'h3de0;
		for (int i = 0; i < 1024; i++)
			rom[i] = 32'h0;
		fill_ram();
		dependent_chain();
		logic_and_shifts();
		load_use();
		overflow_flag();
		random_ops();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end
endmodule

/* files.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/bypass_if.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/forward.sv
verilog/alu.sv
verilog/core_top.sv
verification/core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module core_tb -f files.f -o core_sim &&
./obj_dir/core_sim | tee /dev/stderr | grep -q "^TEST OK$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
